//--- div_unit.f
logic/div_pkg.sv
logic/cla_64.sv
logic/div_ctrl.sv
logic/div_operand_prep.sv
logic/div_iter.sv
logic/div_result_fix.sv
logic/div_unit.sv
tests/div_unit_asserts.sv
tests/div_unit_tb.sv

//--- Makefile
TOP := div_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f div_unit.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f div_unit.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/div_unit_tb.sv
module div_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import div_pkg::*;

  // Directed, special, random, busy and flush operations together.
  localparam int n_random      = 200;
  localparam int num_ops       = 32 + 16 + n_random + 3;
  localparam int timeout_cycles = num_ops * 70 + 100;
  localparam int latency       = 65;

  typedef struct packed {
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    div_op_e         op;
    logic [xlen-1:0] expected;
    int              cyc;
  } pend_t;

  logic            clk;
  logic            rst_n;
  logic [xlen-1:0] dividend;
  logic [xlen-1:0] divisor;
  logic            div_valid;
  div_op_e         div_op;
  logic            flush;
  logic            div_ready;
  logic            out_valid;
  logic [xlen-1:0] result;

  pend_t       pend_q[$];
  int          cyc_cnt;
  int          check_cnt;
  int          err_cnt;
  logic [31:0] lfsr;

  div_unit UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .dividend  (dividend),
    .divisor   (divisor),
    .div_valid (div_valid),
    .div_op    (div_op),
    .flush     (flush),
    .div_ready (div_ready),
    .out_valid (out_valid),
    .result    (result)
  );

  bind div_unit div_unit_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .flush     (flush),
    .div_ready (div_ready),
    .out_valid (out_valid)
  );

  always #5 clk = ~clk;

  // RISC-V division rules, including divide by zero and signed overflow.
  function automatic logic [xlen-1:0] ref_result(input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b,
                                                 input div_op_e op);
    logic signed [xlen-1:0] sa;
    logic signed [xlen-1:0] sb;
    logic [xlen-1:0]        q;
    logic [xlen-1:0]        r;
    sa = a;
    sb = b;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (op[0] && (a == 64'h8000_0000_0000_0000) && (b == '1)) begin
      q = a;
      r = '0;
    end else if (op[0]) begin
      q = sa / sb;
      r = sa % sb;
    end else begin
      q = a / b;
      r = a % b;
    end
    return op[1] ? r : q;
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [xlen-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[xlen-2:0], lfsr[0]};
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!div_ready && n < 200) begin
      tick();
      n++;
    end
    if (!div_ready) begin
      $display("error at %0t: div_ready stayed low for 200 cycles", $time);
      err_cnt++;
    end
  endtask

  task automatic issue(input logic [xlen-1:0] a, input logic [xlen-1:0] b, input div_op_e op);
    wait_ready();
    dividend  = a;
    divisor   = b;
    div_op    = op;
    div_valid = 1'b1;
    tick();
    div_valid = 1'b0;
  endtask

  task automatic issue_all_ops(input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    issue(a, b, op_divu);
    issue(a, b, op_div);
    issue(a, b, op_remu);
    issue(a, b, op_rem);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (pend_q.size() != 0 && n < 200) begin
      tick();
      n++;
    end
    if (pend_q.size() != 0) begin
      $display("error at %0t: %0d operations never completed", $time, pend_q.size());
      err_cnt++;
    end
  endtask

  task automatic report_counts();
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
  endtask

  // Expected results are queued at accept and compared when out_valid arrives.
  always @(posedge clk) begin : compare
    pend_t p;
    cyc_cnt = cyc_cnt + 1;
    if (rst_n) begin
      if (out_valid) begin
        if (pend_q.size() == 0) begin
          $display("error at %0t: out_valid without an operation in flight", $time);
          err_cnt++;
        end else begin
          p = pend_q.pop_front();
          check_cnt++;
          if (result !== p.expected) begin
            $display("mismatch at %0t: op %0d a=%h b=%h result %h expected %h",
                     $time, p.op, p.a, p.b, result, p.expected);
            err_cnt++;
          end
          if (cyc_cnt - p.cyc != latency) begin
            $display("mismatch at %0t: out_valid %0d cycles after accept, expected %0d",
                     $time, cyc_cnt - p.cyc, latency);
            err_cnt++;
          end
        end
      end
      // An aborted operation must never report a result.
      if (flush) begin
        pend_q.delete();
      end
      if (div_valid && div_ready && !flush) begin
        p.a        = dividend;
        p.b        = divisor;
        p.op       = div_op;
        p.expected = ref_result(dividend, divisor, div_op);
        p.cyc      = cyc_cnt;
        pend_q.push_back(p);
      end
    end
  end

  initial begin : watchdog
    repeat (timeout_cycles + 10) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    report_counts();
    $display("sim failed");
    $finish;
  end

  initial begin : stimulus
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] sh;
    logic [xlen-1:0] opb;
    clk       = 1'b0;
    rst_n     = 1'b0;
    dividend  = '0;
    divisor   = '0;
    div_valid = 1'b0;
    div_op    = op_divu;
    flush     = 1'b0;
    cyc_cnt   = 0;
    check_cnt = 0;
    err_cnt   = 0;
    lfsr      = 32'd68;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    tick();
    if (!div_ready || out_valid) begin
      $display("mismatch at %0t: after reset div_ready=%b out_valid=%b", $time,
               div_ready, out_valid);
      err_cnt++;
    end

    // All sign combinations and a few wide operands.
    issue_all_ops(64'd100, 64'd7);
    issue_all_ops(-64'd100, 64'd7);
    issue_all_ops(64'd100, -64'd7);
    issue_all_ops(-64'd100, -64'd7);
    issue_all_ops(64'hFFFF_FFFF_FFFF_FFFF, 64'd3);
    issue_all_ops(64'h8000_0000_0000_0001, 64'hFFFF_FFFF_0000_0000);
    issue_all_ops(64'd5, 64'd10);
    issue_all_ops(64'h0123_4567_89AB_CDEF, 64'h0000_0000_0001_0000);

    issue_all_ops(64'd123, 64'd0);
    issue_all_ops(-64'd5, 64'd0);
    issue_all_ops(64'h8000_0000_0000_0000, 64'd0);
    issue_all_ops(64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);

    // A random shift gives divisors of every size.
    for (int i = 0; i < n_random; i++) begin
      take_bits(64, a);
      take_bits(64, b);
      take_bits(6, sh);
      take_bits(2, opb);
      b = b >> sh[5:0];
      issue(a, b, div_op_e'(opb[1:0]));
    end

    // New requests while busy must be ignored.
    issue(64'd1000, 64'd9, op_div);
    dividend  = 64'hDEAD_BEEF_0000_0001;
    divisor   = 64'd2;
    div_op    = op_remu;
    div_valid = 1'b1;
    repeat (50) tick();
    div_valid = 1'b0;

    issue(64'hFFFF_0000_FFFF_0000, 64'd12345, op_remu);
    repeat (20) tick();
    flush = 1'b1;
    tick();
    flush = 1'b0;
    if (!div_ready) begin
      $display("mismatch at %0t: div_ready low on the cycle after flush", $time);
      err_cnt++;
    end
    issue(-64'd77777, 64'd321, op_rem);

    drain();
    // Any stray out_valid would show up here.
    repeat (80) tick();
    err_cnt = err_cnt + UUT.u_asserts.failures;
    report_counts();
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- tests/div_unit_asserts.sv
module div_unit_asserts (
  input logic clk,
  input logic rst_n,
  input logic load,
  input logic flush,
  input logic div_ready,
  input logic out_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  logic       busy;
  logic [6:0] since_load;
  int         failures = 0;

  // Tracks how long the current operation has been running.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      since_load <= '0;
    end else if (flush) begin
      busy <= 1'b0;
    end else if (load) begin
      busy       <= 1'b1;
      since_load <= '0;
    end else if (out_valid) begin
      busy <= 1'b0;
    end else if (busy) begin
      since_load <= since_load + 7'd1;
    end
  end

  a_pulse: assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
    else begin
      $error("out_valid held for more than one cycle");
      failures++;
    end

  a_not_ready: assert property (@(posedge clk) disable iff (!rst_n) !(out_valid && div_ready))
    else begin
      $error("out_valid and div_ready high together");
      failures++;
    end

  a_load: assert property (@(posedge clk) disable iff (!rst_n) load |-> (div_ready && !busy))
    else begin
      $error("load while div_ready low or an operation in flight");
      failures++;
    end

  a_latency: assert property (@(posedge clk) disable iff (!rst_n) busy |-> since_load <= 7'd64)
    else begin
      $error("no out_valid within 65 cycles of accept");
      failures++;
    end

endmodule

//--- logic/div_unit.sv
module div_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [div_pkg::xlen-1:0] dividend,
  input  logic [div_pkg::xlen-1:0] divisor,
  input  logic                     div_valid,
  input  div_pkg::div_op_e         div_op,
  input  logic                     flush,
  output logic                     div_ready,
  output logic                     out_valid,
  output logic [div_pkg::xlen-1:0] result
);
  import div_pkg::*;

  logic            load;
  logic            step;
  div_op_e         op_r;
  logic [xlen-1:0] dividend_mag;
  logic [xlen-1:0] divisor_mag;
  logic [xlen-1:0] divisor_neg;
  logic            dividend_sign;
  logic            divisor_sign;
  logic            div_zero;
  logic            overflow;
  logic [xlen-1:0] quotient_raw;
  logic [xlen-1:0] remainder_raw;

  div_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .div_valid (div_valid),
    .flush     (flush),
    .div_ready (div_ready),
    .load      (load),
    .step      (step),
    .out_valid (out_valid)
  );

  div_operand_prep u_prep (
    .clk           (clk),
    .rst_n         (rst_n),
    .load          (load),
    .dividend      (dividend),
    .divisor       (divisor),
    .div_op        (div_op),
    .op_r          (op_r),
    .dividend_mag  (dividend_mag),
    .divisor_mag   (divisor_mag),
    .divisor_neg   (divisor_neg),
    .dividend_sign (dividend_sign),
    .divisor_sign  (divisor_sign),
    .div_zero      (div_zero),
    .overflow      (overflow)
  );

  div_iter u_iter (
    .clk           (clk),
    .rst_n         (rst_n),
    .load          (load),
    .step          (step),
    .dividend_mag  (dividend_mag),
    .divisor_mag   (divisor_mag),
    .divisor_neg   (divisor_neg),
    .quotient_raw  (quotient_raw),
    .remainder_raw (remainder_raw)
  );

  // The original dividend is recovered from its magnitude and sign.
  div_result_fix u_fix (
    .op_r          (op_r),
    .dividend      (dividend_mag),
    .quotient_raw  (quotient_raw),
    .remainder_raw (remainder_raw),
    .dividend_sign (dividend_sign),
    .divisor_sign  (divisor_sign),
    .div_zero      (div_zero),
    .overflow      (overflow),
    .result        (result)
  );

endmodule

//--- logic/div_result_fix.sv
module div_result_fix (
  input  div_pkg::div_op_e         op_r,
  input  logic [div_pkg::xlen-1:0] dividend,
  input  logic [div_pkg::xlen-1:0] quotient_raw,
  input  logic [div_pkg::xlen-1:0] remainder_raw,
  input  logic                     dividend_sign,
  input  logic                     divisor_sign,
  input  logic                     div_zero,
  input  logic                     overflow,
  output logic [div_pkg::xlen-1:0] result
);
  import div_pkg::*;

  logic [xlen-1:0] dividend_orig;
  logic [xlen-1:0] quotient;
  logic [xlen-1:0] remainder;

  // The dividend port carries the stored magnitude, so rebuild the original.
  assign dividend_orig = dividend_sign ? -dividend : dividend;

  always_comb begin
    quotient  = (dividend_sign ^ divisor_sign) ? -quotient_raw : quotient_raw;
    remainder = dividend_sign ? -remainder_raw : remainder_raw;
    if (div_zero) begin
      quotient  = '1;
      remainder = dividend_orig;
    end else if (overflow) begin
      quotient  = dividend_orig;
      remainder = '0;
    end
  end

  assign result = op_r[1] ? remainder : quotient;

endmodule

//--- logic/div_iter.sv
module div_iter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load,
  input  logic                     step,
  input  logic [div_pkg::xlen-1:0] dividend_mag,
  input  logic [div_pkg::xlen-1:0] divisor_mag,
  input  logic [div_pkg::xlen-1:0] divisor_neg,
  output logic [div_pkg::xlen-1:0] quotient_raw,
  output logic [div_pkg::xlen-1:0] remainder_raw
);
  import div_pkg::*;

  // Upper half is the partial remainder, lower half the dividend bits still to
  // be consumed followed by the quotient bits produced so far.
  logic [2*xlen-1:0] pr_q;
  // The partial remainder needs one bit more than xlen; this is its sign.
  logic              pr_sign;
  logic [xlen-1:0]   restore_r;
  // The operand magnitudes settle one cycle after load, so the first step
  // starts from them directly instead of from pr_q.
  logic              first;
  logic [2*xlen-1:0] cur;

  logic [xlen-1:0]   shifted;
  logic [xlen-1:0]   addend;
  logic [xlen-1:0]   sum;
  logic              cout;
  logic              new_sign;
  logic [xlen-1:0]   rem_now;

  assign cur     = first ? {{xlen{1'b0}}, dividend_mag} : pr_q;
  assign shifted = cur[2*xlen-2:xlen-1];
  assign addend  = pr_sign ? divisor_mag : divisor_neg;

  cla_64 u_cla (
    .a    (shifted),
    .b    (addend),
    .cin  (1'b0),
    .sum  (sum),
    .cout (cout)
  );

  // Bit xlen of the sum, built from the shifted-out bit and the extended addend.
  assign new_sign = cur[2*xlen-1] ^ ~pr_sign ^ cout;

  // When the partial remainder is negative, the true remainder is the shifted
  // value kept from before the step that went negative.
  assign rem_now = pr_sign ? restore_r : cur[2*xlen-1:xlen];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pr_sign <= 1'b0;
      first   <= 1'b0;
    end else if (load) begin
      pr_sign <= 1'b0;
      first   <= 1'b1;
    end else if (step) begin
      pr_sign <= new_sign;
      first   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      pr_q      <= {sum, cur[xlen-2:0], ~new_sign};
      restore_r <= {rem_now[xlen-2:0], cur[xlen-1]};
    end
  end

  assign quotient_raw  = pr_q[xlen-1:0];
  assign remainder_raw = rem_now;

endmodule

//--- logic/div_operand_prep.sv
module div_operand_prep (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load,
  input  logic [div_pkg::xlen-1:0] dividend,
  input  logic [div_pkg::xlen-1:0] divisor,
  input  div_pkg::div_op_e         div_op,
  output div_pkg::div_op_e         op_r,
  output logic [div_pkg::xlen-1:0] dividend_mag,
  output logic [div_pkg::xlen-1:0] divisor_mag,
  output logic [div_pkg::xlen-1:0] divisor_neg,
  output logic                     dividend_sign,
  output logic                     divisor_sign,
  output logic                     div_zero,
  output logic                     overflow
);
  import div_pkg::*;

  logic            dvd_neg;
  logic            dvs_neg;
  logic [xlen-1:0] dvd_abs;
  logic [xlen-1:0] dvs_abs;
  logic            min_by_neg_one;

  // Unsigned operations treat the top bit as magnitude.
  assign dvd_neg = div_op[0] & dividend[xlen-1];
  assign dvs_neg = div_op[0] & divisor[xlen-1];
  assign dvd_abs = dvd_neg ? -dividend : dividend;
  assign dvs_abs = dvs_neg ? -divisor : divisor;

  assign min_by_neg_one = (dividend == {1'b1, {(xlen - 1){1'b0}}}) && (&divisor);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_r          <= op_divu;
      dividend_sign <= 1'b0;
      divisor_sign  <= 1'b0;
      div_zero      <= 1'b0;
      overflow      <= 1'b0;
    end else if (load) begin
      op_r          <= div_op;
      dividend_sign <= dvd_neg;
      divisor_sign  <= dvs_neg;
      div_zero      <= (divisor == '0);
      overflow      <= ((div_op == op_div) || (div_op == op_rem)) && min_by_neg_one;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      dividend_mag <= dvd_abs;
      divisor_mag  <= dvs_abs;
      // Subtracting the divisor is done as an add of its negation.
      divisor_neg  <= -dvs_abs;
    end
  end

endmodule

//--- logic/div_ctrl.sv
module div_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic div_valid,
  input  logic flush,
  output logic div_ready,
  output logic load,
  output logic step,
  output logic out_valid
);
  import div_pkg::*;

  div_state_e       state;
  logic [cnt_w-1:0] cnt;

  // New work is taken only while idle, and never in the same cycle as a flush.
  assign div_ready = (state == s_idle);
  assign load      = div_ready && div_valid && !flush;
  assign step      = (state == s_run);
  assign out_valid = (state == s_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_idle;
      cnt   <= '0;
    end else if (flush) begin
      // Abort whatever is in flight.
      state <= s_idle;
      cnt   <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (div_valid) begin
            state <= s_run;
            cnt   <= cnt_w'(div_steps);
          end
        end
        s_run: begin
          cnt <= cnt - 1'b1;
          // Last iteration happens in this cycle, so the counter reaches zero here.
          if (cnt == cnt_w'(1)) begin
            state <= s_done;
          end
        end
        s_done: begin
          state <= s_idle;
        end
        default: begin
          state <= s_idle;
          cnt   <= '0;
        end
      endcase
    end
  end

endmodule

//--- logic/cla_64.sv
module cla_64 (
  input  logic [div_pkg::xlen-1:0] a,
  input  logic [div_pkg::xlen-1:0] b,
  input  logic                     cin,
  output logic [div_pkg::xlen-1:0] sum,
  output logic                     cout
);
  import div_pkg::*;

  logic [xlen-1:0]   g;
  logic [xlen-1:0]   p;
  logic [xlen/4-1:0] grp_g;
  logic [xlen/4-1:0] grp_p;
  logic [xlen/4:0]   grp_c;

  assign g = a & b;
  assign p = a ^ b;

  // First level: each 4-bit group resolves its own carries from the group carry-in.
  for (genvar i = 0; i < xlen / 4; i++) begin : gen_group
    logic [3:0] gg;
    logic [3:0] gp;
    logic [3:0] c;

    assign gg = g[4*i +: 4];
    assign gp = p[4*i +: 4];

    assign c[0] = grp_c[i];
    assign c[1] = gg[0] | (gp[0] & grp_c[i]);
    assign c[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & grp_c[i]);
    assign c[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0])
                | (gp[2] & gp[1] & gp[0] & grp_c[i]);

    assign grp_g[i] = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1])
                    | (gp[3] & gp[2] & gp[1] & gg[0]);
    assign grp_p[i] = &gp;

    assign sum[4*i +: 4] = gp ^ c;
  end

  // Second level: every group carry is expanded directly from the group
  // generate and propagate terms, so no carry ripples between groups.
  always_comb begin
    logic run_p;

    grp_c[0] = cin;
    for (int k = 0; k < xlen / 4; k++) begin
      grp_c[k+1] = grp_g[k];
      run_p      = grp_p[k];
      for (int j = k - 1; j >= 0; j--) begin
        grp_c[k+1] = grp_c[k+1] | (run_p & grp_g[j]);
        run_p      = run_p & grp_p[j];
      end
      grp_c[k+1] = grp_c[k+1] | (run_p & cin);
    end
  end

  assign cout = grp_c[xlen/4];

endmodule

//--- logic/div_pkg.sv
package div_pkg;

  // Operand and result width of the execute stage.
  localparam int xlen = 64;

  // One quotient bit is produced per iteration cycle.
  localparam int div_steps = 64;

  // Wide enough to hold div_steps itself.
  localparam int cnt_w = 7;

  // Bit 0 selects signed operands, bit 1 selects the remainder as result.
  typedef enum logic [1:0] {
    op_divu = 2'b00,
    op_div  = 2'b01,
    op_remu = 2'b10,
    op_rem  = 2'b11
  } div_op_e;

  // Controller states.
  // s_idle accepts a new operation, s_run iterates and s_done presents the result.
  typedef enum logic [1:0] {
    s_idle,
    s_run,
    s_done
  } div_state_e;

endpackage
